/* src/mipsExec_params.svh */
// Data widths, opcode values and funct values
// for the execute slice
`ifndef MIPS_EXEC_PARAMS_SVH
`define MIPS_EXEC_PARAMS_SVH

`define MIPS_DATA_W 32 // Data and instruction width
`define MIPS_REG_W  5  // Register address width

// Opcodes in instr[31:26]
`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_ADDI  6'b001000
`define OP_SLTI  6'b001010
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_SW    6'b101011

// Funct codes in instr[5:0]
`define FN_JR    6'b001000
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_NOR   6'b100111
`define FN_SLT   6'b101010

`endif

/* src/mipsExecPkg.sv */
// Enums and packed structs carried between the execute stages
`default_nettype none

`include "mipsExec_params.svh"

package mipsExecPkg;

  // --------------------------------------
  // Control encodings
  // --------------------------------------

  // Class handed from main control to ALU control
  typedef enum logic [2:0] {
    ALUOP_ADD,
    ALUOP_SUB,
    ALUOP_RTYPE, // Look at funct
    ALUOP_AND,
    ALUOP_OR,
    ALUOP_XOR,
    ALUOP_SLT,
    ALUOP_LUI
  } aluOpT;

  // Function actually performed by the ALU
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_LUI
  } aluOperationT;

  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regDstT;      // Write register select
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} memToRegT;   // Writeback source
  typedef enum logic [1:0] {JMP_NONE, JMP_J, JMP_JAL, JMP_JR} jumpT;

  // --------------------------------------
  // Stage payloads
  // --------------------------------------

  typedef struct packed {
    regDstT   regDst;
    logic     branch;     // beq
    logic     memRead;
    memToRegT memToReg;
    aluOpT    aluOp;
    logic     memWrite;
    logic     aluSrc;     // Immediate as second operand
    logic     regWrite;
    jumpT     jump;
    logic     zeroExtend; // Logical immediates
    logic     illegal;    // Unknown opcode
  } ctrlT;

  typedef struct packed {
    ctrlT                   ctrl;
    aluOperationT           operation;
    logic [`MIPS_DATA_W-1:0] opA;
    logic [`MIPS_DATA_W-1:0] opB;
    logic [`MIPS_DATA_W-1:0] storeData; // rt value for sw
    logic [`MIPS_REG_W-1:0]  rt;
    logic [`MIPS_REG_W-1:0]  rd;
  } decodedT;

  typedef struct packed {
    ctrlT                   ctrl;
    logic [`MIPS_DATA_W-1:0] result;
    logic                   zero;
    logic [`MIPS_DATA_W-1:0] storeData;
    logic [`MIPS_REG_W-1:0]  rt;
    logic [`MIPS_REG_W-1:0]  rd;
  } executedT;

  typedef struct packed {
    logic [`MIPS_DATA_W-1:0] result;
    logic                   zero;
    logic                   branchTaken;
    logic                   regWrite;
    logic [`MIPS_REG_W-1:0]  writeReg;
    logic                   memRead;
    logic                   memWrite;
    memToRegT               memToReg;
    logic [`MIPS_DATA_W-1:0] storeData;
    jumpT                   jump;
    logic                   illegal;
  } execOutT;

endpackage

`default_nettype wire

/* src/mainControl.sv */
// Main control decoder from opcode to control struct
`timescale 1ns/1ns
`default_nettype none

`include "mipsExec_params.svh"

module mainControl (
  input  wire logic [5:0]        opcode,
  input  wire logic [5:0]        funct,  // Only to spot jr
  output mipsExecPkg::ctrlT      ctrl
);

  always_comb begin
    // Defaults describe a harmless nop
    ctrl.regDst     = mipsExecPkg::DST_RT;
    ctrl.branch     = 1'b0;
    ctrl.memRead    = 1'b0;
    ctrl.memToReg   = mipsExecPkg::WB_ALU;
    ctrl.aluOp      = mipsExecPkg::ALUOP_ADD;
    ctrl.memWrite   = 1'b0;
    ctrl.aluSrc     = 1'b0;
    ctrl.regWrite   = 1'b0;
    ctrl.jump       = mipsExecPkg::JMP_NONE;
    ctrl.zeroExtend = 1'b0;
    ctrl.illegal    = 1'b0;

    case (opcode)
      `OP_RTYPE: begin
        if (funct == `FN_JR) begin
          ctrl.jump = mipsExecPkg::JMP_JR; // No register written
        end else begin
          ctrl.regDst   = mipsExecPkg::DST_RD;
          ctrl.aluOp    = mipsExecPkg::ALUOP_RTYPE;
          ctrl.regWrite = 1'b1;
        end
      end
      // Immediate arithmetic and logic
      `OP_ADDI: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      `OP_SLTI: begin
        ctrl.aluOp    = mipsExecPkg::ALUOP_SLT;
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      `OP_ANDI, `OP_ORI, `OP_XORI: begin
        ctrl.aluOp      = (opcode == `OP_ANDI) ? mipsExecPkg::ALUOP_AND :
                          (opcode == `OP_ORI)  ? mipsExecPkg::ALUOP_OR  :
                                                 mipsExecPkg::ALUOP_XOR;
        ctrl.aluSrc     = 1'b1;
        ctrl.regWrite   = 1'b1;
        ctrl.zeroExtend = 1'b1; // Logical ops take unsigned imm
      end
      `OP_LUI: begin
        ctrl.aluOp    = mipsExecPkg::ALUOP_LUI;
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      // Memory access, base plus offset
      `OP_LW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = mipsExecPkg::WB_MEM;
        ctrl.regWrite = 1'b1;
      end
      `OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      `OP_BEQ: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = mipsExecPkg::ALUOP_SUB; // Equal gives zero
      end
      `OP_J:   ctrl.jump = mipsExecPkg::JMP_J;
      `OP_JAL: begin
        ctrl.jump     = mipsExecPkg::JMP_JAL;
        ctrl.regDst   = mipsExecPkg::DST_RA;   // Link into r31
        ctrl.memToReg = mipsExecPkg::WB_LINK;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl.illegal = 1'b1; // All enables stay low
    endcase
  end

endmodule

`default_nettype wire

/* src/aluControl.sv */
// ALU control from operation class and funct field
`timescale 1ns/1ns
`default_nettype none

`include "mipsExec_params.svh"

module aluControl (
  input  wire mipsExecPkg::aluOpT   aluOp,
  input  wire logic [5:0]           funct,
  output mipsExecPkg::aluOperationT operation
);

  // --------------------------------------
  // R-type funct decode
  // --------------------------------------
  mipsExecPkg::aluOperationT rOperation;

  always_comb begin
    case (funct)
      `FN_ADD: rOperation = mipsExecPkg::ALU_ADD;
      `FN_SUB: rOperation = mipsExecPkg::ALU_SUB;
      `FN_AND: rOperation = mipsExecPkg::ALU_AND;
      `FN_OR:  rOperation = mipsExecPkg::ALU_OR;
      `FN_XOR: rOperation = mipsExecPkg::ALU_XOR;
      `FN_NOR: rOperation = mipsExecPkg::ALU_NOR;
      `FN_SLT: rOperation = mipsExecPkg::ALU_SLT;
      default: rOperation = mipsExecPkg::ALU_ADD; // jr and unknowns
    endcase
  end

  // --------------------------------------
  // Class to operation
  // --------------------------------------
  always_comb begin
    case (aluOp)
      mipsExecPkg::ALUOP_RTYPE: operation = rOperation;
      mipsExecPkg::ALUOP_SUB:   operation = mipsExecPkg::ALU_SUB; // beq
      mipsExecPkg::ALUOP_AND:   operation = mipsExecPkg::ALU_AND;
      mipsExecPkg::ALUOP_OR:    operation = mipsExecPkg::ALU_OR;
      mipsExecPkg::ALUOP_XOR:   operation = mipsExecPkg::ALU_XOR;
      mipsExecPkg::ALUOP_SLT:   operation = mipsExecPkg::ALU_SLT; // slti
      mipsExecPkg::ALUOP_LUI:   operation = mipsExecPkg::ALU_LUI;
      default:                  operation = mipsExecPkg::ALU_ADD; // addi, lw, sw
    endcase
  end

endmodule

`default_nettype wire

/* src/instrDecode.sv */
// Input stage with field split, control decode,
// immediate extension and operand select
`timescale 1ns/1ns
`default_nettype none

`include "mipsExec_params.svh"

module instrDecode (
  input  wire logic                    begintest,
  input  wire logic                    reset,
  input  wire logic                    issue,    // One-cycle strobe
  input  wire logic [`MIPS_DATA_W-1:0] instr,
  input  wire logic [`MIPS_DATA_W-1:0] rsData,
  input  wire logic [`MIPS_DATA_W-1:0] rtData,
  output mipsExecPkg::decodedT         dec,
  output logic                         decValid
);

  localparam int HalfW = `MIPS_DATA_W / 2;

  // --------------------------------------
  // Field split
  // --------------------------------------
  logic [5:0]              opcode;
  logic [5:0]              funct;
  logic [HalfW-1:0]        imm16;
  logic [`MIPS_DATA_W-1:0] immExt;

  mipsExecPkg::ctrlT         ctrl;
  mipsExecPkg::aluOperationT operation;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign imm16  = instr[HalfW-1:0];

  mainControl u_mainControl (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  aluControl u_aluControl (
    .aluOp     (ctrl.aluOp),
    .funct     (funct),
    .operation (operation)
  );

  // Zero extension for logical immediates, sign otherwise
  assign immExt = ctrl.zeroExtend ? {{HalfW{1'b0}}, imm16}
                                  : {{HalfW{imm16[HalfW-1]}}, imm16};

  // --------------------------------------
  // Stage register
  // --------------------------------------
  always_ff @(posedge begintest) begin
    if (reset) begin
      decValid <= 1'b0;
    end else begin
      decValid <= issue; // Accepted every cycle
    end
  end

  // Payload held between issues
  always_ff @(posedge begintest) begin
    if (issue) begin
      dec.ctrl      <= ctrl;
      dec.operation <= operation;
      dec.opA       <= rsData;
      dec.opB       <= ctrl.aluSrc ? immExt : rtData;
      dec.storeData <= rtData;                // sw data
      dec.rt        <= instr[20:16];
      dec.rd        <= instr[15:11];
    end
  end

endmodule

`default_nettype wire

/* src/alu.sv */
// Processing stage with the ALU and its result register
`timescale 1ns/1ns
`default_nettype none

`include "mipsExec_params.svh"

module alu (
  input  wire logic              begintest,
  input  wire logic              reset,
  input  wire mipsExecPkg::decodedT dec,
  input  wire logic              decValid,
  output mipsExecPkg::executedT  exe,
  output logic                   exeValid
);

  localparam int HalfW = `MIPS_DATA_W / 2;

  logic [`MIPS_DATA_W-1:0] result;

  // --------------------------------------
  // Arithmetic and logic
  // --------------------------------------
  always_comb begin
    case (dec.operation)
      mipsExecPkg::ALU_ADD: result = dec.opA + dec.opB;
      mipsExecPkg::ALU_SUB: result = dec.opA - dec.opB;
      mipsExecPkg::ALU_AND: result = dec.opA & dec.opB;
      mipsExecPkg::ALU_OR:  result = dec.opA | dec.opB;
      mipsExecPkg::ALU_XOR: result = dec.opA ^ dec.opB;
      mipsExecPkg::ALU_NOR: result = ~(dec.opA | dec.opB);
      mipsExecPkg::ALU_SLT: begin
        // Signed compare gives 1 or 0
        result = {{(`MIPS_DATA_W-1){1'b0}}, ($signed(dec.opA) < $signed(dec.opB))};
      end
      mipsExecPkg::ALU_LUI: result = {dec.opB[HalfW-1:0], {HalfW{1'b0}}}; // Upper half
      default:              result = dec.opA + dec.opB;
    endcase
  end

  // --------------------------------------
  // Stage register
  // --------------------------------------
  always_ff @(posedge begintest) begin
    if (reset) begin
      exeValid <= 1'b0;
    end else begin
      exeValid <= decValid;
    end
  end

  always_ff @(posedge begintest) begin
    if (decValid) begin
      exe.ctrl      <= dec.ctrl;      // Controls ride along
      exe.result    <= result;
      exe.zero      <= (result == '0);
      exe.storeData <= dec.storeData;
      exe.rt        <= dec.rt;
      exe.rd        <= dec.rd;
    end
  end

endmodule

`default_nettype wire

/* src/resultStage.sv */
// Output stage with branch decision, write register and gated flags
`timescale 1ns/1ns
`default_nettype none

module resultStage (
  input  wire logic              begintest,
  input  wire logic              reset,
  input  wire mipsExecPkg::executedT exe,
  input  wire logic              exeValid,
  output mipsExecPkg::execOutT   out,
  output logic                   outValid
);

  mipsExecPkg::execOutT nextOut;

  always_comb begin
    nextOut.result      = exe.result;
    nextOut.zero        = exe.zero;
    nextOut.branchTaken = exe.ctrl.branch & exe.zero & exeValid; // beq taken
    nextOut.regWrite    = exe.ctrl.regWrite & exeValid;
    nextOut.memRead     = exe.ctrl.memRead & exeValid;
    nextOut.memWrite    = exe.ctrl.memWrite & exeValid;
    nextOut.memToReg    = exe.ctrl.memToReg;
    nextOut.storeData   = exe.storeData;
    nextOut.jump        = exeValid ? exe.ctrl.jump : mipsExecPkg::JMP_NONE;
    nextOut.illegal     = exe.ctrl.illegal & exeValid;
    case (exe.ctrl.regDst)
      mipsExecPkg::DST_RD: nextOut.writeReg = exe.rd;
      mipsExecPkg::DST_RA: nextOut.writeReg = '1;   // r31 for jal
      default:             nextOut.writeReg = exe.rt;
    endcase
  end

  always_ff @(posedge begintest) begin
    outValid <= reset ? 1'b0 : exeValid;
    out      <= nextOut;
    if (reset) begin
      // Flags read inactive out of reset
      out.branchTaken <= 1'b0;
      out.regWrite    <= 1'b0;
      out.memRead     <= 1'b0;
      out.memWrite    <= 1'b0;
      out.jump        <= mipsExecPkg::JMP_NONE;
      out.illegal     <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/mipsExec.sv */
// Top level of the three-stage execute slice
`timescale 1ns/1ns
`default_nettype none

`include "mipsExec_params.svh"

module mipsExec (
  input  wire logic                    begintest,
  input  wire logic                    reset,
  input  wire logic                    issue,
  input  wire logic [`MIPS_DATA_W-1:0] instr,
  input  wire logic [`MIPS_DATA_W-1:0] rsData,
  input  wire logic [`MIPS_DATA_W-1:0] rtData,
  output mipsExecPkg::execOutT         out,
  output logic                         outValid // 3 edges after issue
);

  mipsExecPkg::decodedT  dec;  // Decode to ALU
  logic                  decValid;
  mipsExecPkg::executedT exe;  // ALU to output
  logic                  exeValid;

  instrDecode u_instrDecode (
    .begintest (begintest),
    .reset     (reset),
    .issue     (issue),
    .instr     (instr),
    .rsData    (rsData),
    .rtData    (rtData),
    .dec       (dec),
    .decValid  (decValid)
  );

  alu u_alu (
    .begintest (begintest),
    .reset     (reset),
    .dec       (dec),
    .decValid  (decValid),
    .exe       (exe),
    .exeValid  (exeValid)
  );

  resultStage u_resultStage (
    .begintest (begintest),
    .reset     (reset),
    .exe       (exe),
    .exeValid  (exeValid),
    .out       (out),
    .outValid  (outValid)
  );

endmodule

`default_nettype wire

/* bench/mipsExecRef.svh */
// Reference model giving the expected output of one instruction
`ifndef MIPS_EXEC_REF_SVH
`define MIPS_EXEC_REF_SVH

`include "mipsExec_params.svh"

// Expected top-level output for an instruction and its two operands
function automatic mipsExecPkg::execOutT refExec(input logic [`MIPS_DATA_W-1:0] ins,
                                                 input logic [`MIPS_DATA_W-1:0] rs,
                                                 input logic [`MIPS_DATA_W-1:0] rt);
  mipsExecPkg::execOutT    e;
  logic [`MIPS_DATA_W-1:0] sImm;
  logic [`MIPS_DATA_W-1:0] zImm;
  sImm = {{16{ins[15]}}, ins[15:0]}; // Arithmetic, compare, memory
  zImm = {16'h0000, ins[15:0]};      // Logical immediates
  e = '0;                            // Enables low, WB_ALU, JMP_NONE
  e.storeData = rt;                  // sw data is always the rt value
  e.writeReg  = ins[20:16];          // I-type writes rt
  case (ins[31:26])
    `OP_RTYPE: begin
      e.writeReg = ins[15:11];
      e.regWrite = 1'b1;
      case (ins[5:0])
        `FN_SUB: e.result = rs - rt;
        `FN_AND: e.result = rs & rt;
        `FN_OR:  e.result = rs | rt;
        `FN_XOR: e.result = rs ^ rt;
        `FN_NOR: e.result = ~(rs | rt);
        `FN_SLT: e.result = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
        `FN_JR: begin
          e.jump     = mipsExecPkg::JMP_JR;
          e.regWrite = 1'b0;
        end
        default: e.result = rs + rt; // add and unknown funct
      endcase
    end
    `OP_ADDI: e.result = rs + sImm;
    `OP_SLTI: e.result = ($signed(rs) < $signed(sImm)) ? 32'd1 : 32'd0;
    `OP_ANDI: e.result = rs & zImm;
    `OP_ORI:  e.result = rs | zImm;
    `OP_XORI: e.result = rs ^ zImm;
    `OP_LUI:  e.result = {ins[15:0], 16'h0000};
    `OP_LW: begin
      e.result   = rs + sImm; // Base plus offset
      e.memRead  = 1'b1;
      e.memToReg = mipsExecPkg::WB_MEM;
    end
    `OP_SW: begin
      e.result   = rs + sImm;
      e.memWrite = 1'b1;
    end
    `OP_BEQ: begin
      e.result      = rs - rt;
      e.branchTaken = (rs == rt);
    end
    `OP_J: e.jump = mipsExecPkg::JMP_J;
    `OP_JAL: begin
      e.jump     = mipsExecPkg::JMP_JAL;
      e.writeReg = 5'd31;            // Link register
      e.memToReg = mipsExecPkg::WB_LINK;
    end
    default: e.illegal = 1'b1;
  endcase
  // Register writers among the I-types
  case (ins[31:26])
    `OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_LW, `OP_JAL: e.regWrite = 1'b1;
    default: ;
  endcase
  e.zero = (e.result == '0);
  return e;
endfunction

`endif

/* bench/mipsExecTb.sv */
// Directed testbench for the execute slice, checked against a reference model
`timescale 1ns/1ns
`default_nettype none

module mipsExecTb;

  `include "mipsExecRef.svh"

  localparam int TimeoutCycles = 20; // Per wait

  logic                    begintest;
  logic                    reset;
  logic                    issue;
  logic [`MIPS_DATA_W-1:0] instr;
  logic [`MIPS_DATA_W-1:0] rsData;
  logic [`MIPS_DATA_W-1:0] rtData;
  mipsExecPkg::execOutT    dutOut;
  logic                    outValid;
  integer                  seed;

  mipsExec u_mipsExec (
    .begintest (begintest),
    .reset     (reset),
    .issue     (issue),
    .instr     (instr),
    .rsData    (rsData),
    .rtData    (rtData),
    .out       (dutOut),
    .outValid  (outValid)
  );

  always #5 begintest = ~begintest; // 10 ns period

  // --------------------------------------
  // Error reporting
  // --------------------------------------
  task automatic abortRun;
    $display("TB FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic errorLine(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    abortRun();
  endtask

  task automatic timeoutAbort(input string name);
    $display("Timeout: outValid never came for %s within %0d cycles", name, TimeoutCycles);
    abortRun();
  endtask

  task automatic compareField(input string name, input string field,
                              input logic [31:0] got, input logic [31:0] expv);
    assert (got === expv)
      else errorLine($sformatf("%s %s got 0x%08h expected 0x%08h", name, field, got, expv));
  endtask

  // Full output against the model with don't-care fields skipped
  task automatic matchOutput(input string name, input mipsExecPkg::execOutT exp);
    assert (outValid === 1'b1) else errorLine($sformatf("%s outValid is low", name));
    compareField(name, "regWrite", 32'(dutOut.regWrite), 32'(exp.regWrite));
    compareField(name, "memRead", 32'(dutOut.memRead), 32'(exp.memRead));
    compareField(name, "memWrite", 32'(dutOut.memWrite), 32'(exp.memWrite));
    compareField(name, "branchTaken", 32'(dutOut.branchTaken), 32'(exp.branchTaken));
    compareField(name, "jump", 32'(dutOut.jump), 32'(exp.jump));
    compareField(name, "illegal", 32'(dutOut.illegal), 32'(exp.illegal));
    compareField(name, "storeData", dutOut.storeData, exp.storeData);
    if (exp.regWrite) begin
      compareField(name, "writeReg", 32'(dutOut.writeReg), 32'(exp.writeReg));
      compareField(name, "memToReg", 32'(dutOut.memToReg), 32'(exp.memToReg));
    end
    if (exp.jump == mipsExecPkg::JMP_NONE && !exp.illegal) begin // ALU in use
      compareField(name, "result", dutOut.result, exp.result);
      compareField(name, "zero", 32'(dutOut.zero), 32'(exp.zero));
    end
  endtask

  // --------------------------------------
  // Stimulus helpers
  // --------------------------------------
  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic driveIssue(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
    @(negedge begintest);
    issue  = 1'b1;
    instr  = ins;
    rsData = a;
    rtData = b;
  endtask

  // Counts falling edges until outValid, drops the strobe on the way
  task automatic awaitOutValid(input string name, output int cycles);
    cycles = 0;
    do begin
      @(negedge begintest);
      issue = 1'b0;
      cycles++;
      if (cycles > TimeoutCycles) timeoutAbort(name);
    end while (outValid !== 1'b1);
  endtask

  task automatic runInstr(input string name, input logic [31:0] ins,
                          input logic [31:0] a, input logic [31:0] b);
    mipsExecPkg::execOutT exp;
    int                   cycles;
    exp = refExec(ins, a, b);
    driveIssue(ins, a, b);
    awaitOutValid(name, cycles);
    assert (cycles == 3)
      else errorLine($sformatf("%s outValid after %0d cycles expected 3", name, cycles));
    matchOutput(name, exp);
  endtask

  // --------------------------------------
  // Directed tests
  // --------------------------------------
  task automatic resetState;
    int i;
    for (i = 0; i < 3; i++) begin
      @(negedge begintest);
      assert (outValid === 1'b0) else errorLine("outValid high after reset");
      compareField("reset", "regWrite", 32'(dutOut.regWrite), 32'd0);
      compareField("reset", "memRead", 32'(dutOut.memRead), 32'd0);
      compareField("reset", "memWrite", 32'(dutOut.memWrite), 32'd0);
      compareField("reset", "branchTaken", 32'(dutOut.branchTaken), 32'd0);
      compareField("reset", "jump", 32'(dutOut.jump), 32'(mipsExecPkg::JMP_NONE));
    end
  endtask

  task automatic rTypeOps;
    logic [5:0] fns [7];
    int         k;
    fns = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT};
    runInstr("add fixed", encodeR(5'd1, 5'd2, 5'd3, `FN_ADD), 32'd30, 32'd1);
    compareField("add fixed", "result", dutOut.result, 32'd31);
    runInstr("sub fixed", encodeR(5'd4, 5'd5, 5'd6, `FN_SUB), 32'd45, 32'd5);
    compareField("sub fixed", "result", dutOut.result, 32'd40);
    runInstr("slt less", encodeR(5'd7, 5'd8, 5'd9, `FN_SLT), 32'd5, 32'd6);
    runInstr("slt not less", encodeR(5'd7, 5'd8, 5'd10, `FN_SLT), 32'd7, 32'd6);
    compareField("slt not less", "zero", 32'(dutOut.zero), 32'd1);
    runInstr("slt signed", encodeR(5'd1, 5'd1, 5'd11, `FN_SLT), 32'hFFFF_FFFF, 32'd1);
    runInstr("and fixed", encodeR(5'd2, 5'd3, 5'd12, `FN_AND), 32'hF0F0_1234, 32'h0FF0_FF00);
    runInstr("or fixed", encodeR(5'd2, 5'd3, 5'd13, `FN_OR), 32'hF000_0001, 32'h0000_00F0);
    runInstr("xor fixed", encodeR(5'd2, 5'd3, 5'd14, `FN_XOR), 32'hAAAA_5555, 32'hFFFF_0000);
    runInstr("nor fixed", encodeR(5'd2, 5'd3, 5'd15, `FN_NOR), 32'h0000_FFFF, 32'h00FF_0000);
    for (k = 0; k < 21; k++) begin // Three random passes over the functs
      runInstr($sformatf("rtype random %0d", k), encodeR(5'(k), 5'(k + 1), 5'(k + 9), fns[k % 7]),
               $random(seed), $random(seed));
    end
  endtask

  task automatic immediateOps;
    runInstr("xori small", encodeI(`OP_XORI, 5'd1, 5'd2, 16'h0006), 32'd5, 32'd0);
    compareField("xori small", "result", dutOut.result, 32'd3);
    runInstr("xori negative", encodeI(`OP_XORI, 5'd1, 5'd3, 16'h8006), 32'd5, 32'd0);
    runInstr("andi", encodeI(`OP_ANDI, 5'd1, 5'd4, 16'h8F0F), 32'hFFFF_FFFF, 32'd0);
    runInstr("ori", encodeI(`OP_ORI, 5'd1, 5'd5, 16'hF000), 32'h1234_0001, 32'd0);
    runInstr("addi negative", encodeI(`OP_ADDI, 5'd1, 5'd6, 16'hFFFD), 32'd10, 32'd0);
    runInstr("slti negative", encodeI(`OP_SLTI, 5'd1, 5'd7, 16'hFFFF), 32'hFFFF_FFF0, 32'd0);
    runInstr("slti false", encodeI(`OP_SLTI, 5'd1, 5'd8, 16'hFFFF), 32'd0, 32'd0);
    runInstr("lui", encodeI(`OP_LUI, 5'd0, 5'd9, 16'hABCD), 32'h5555_5555, 32'd0);
    compareField("lui", "result", dutOut.result, 32'hABCD_0000);
  endtask

  task automatic branchZero;
    runInstr("beq equal", encodeI(`OP_BEQ, 5'd1, 5'd2, 16'h0010), 32'h1234, 32'h1234);
    compareField("beq equal", "branchTaken", 32'(dutOut.branchTaken), 32'd1);
    runInstr("beq unequal", encodeI(`OP_BEQ, 5'd1, 5'd2, 16'h0010), 32'h1234, 32'h1235);
  endtask

  task automatic memJumpFlags;
    runInstr("lw", encodeI(`OP_LW, 5'd4, 5'd5, 16'hFFFC), 32'h0000_1000, 32'd0);
    runInstr("sw", encodeI(`OP_SW, 5'd4, 5'd6, 16'h0010), 32'h0000_2000, 32'hDEAD_BEEF);
    runInstr("jal", {`OP_JAL, 26'h0000_123}, 32'd0, 32'd0);
    runInstr("j", {`OP_J, 26'h0000_456}, 32'd0, 32'd0);
    runInstr("jr", encodeR(5'd31, 5'd0, 5'd0, `FN_JR), 32'h0040_0000, 32'd0);
    runInstr("illegal", encodeI(6'b111111, 5'd1, 5'd2, 16'h0001), 32'd1, 32'd2);
  endtask

  task automatic backToBack;
    mipsExecPkg::execOutT exp [3];
    logic [31:0]          ins [3];
    logic [31:0]          a [3];
    logic [31:0]          b [3];
    int                   cycles;
    int                   k;
    ins[0] = encodeR(5'd1, 5'd2, 5'd3, `FN_ADD);
    a[0]   = 32'd100;
    b[0]   = 32'd23;
    ins[1] = encodeI(`OP_ORI, 5'd4, 5'd7, 16'h00F0);
    a[1]   = 32'h0F00_000F;
    b[1]   = 32'd0;
    ins[2] = encodeI(`OP_SW, 5'd8, 5'd9, 16'h0004);
    a[2]   = 32'h0000_0400;
    b[2]   = 32'hCAFE_F00D;
    for (k = 0; k < 3; k++) begin // One issue per cycle
      exp[k] = refExec(ins[k], a[k], b[k]);
      driveIssue(ins[k], a[k], b[k]);
    end
    awaitOutValid("pipeline", cycles);
    assert (cycles == 1)
      else errorLine($sformatf("pipeline first result after %0d cycles expected 3", cycles + 2));
    for (k = 0; k < 3; k++) begin
      if (k > 0) @(negedge begintest);
      matchOutput($sformatf("pipeline slot %0d", k), exp[k]);
    end
    @(negedge begintest);
    assert (outValid === 1'b0) else errorLine("pipeline outValid high after the last result");
    compareField("pipeline idle", "memWrite", 32'(dutOut.memWrite), 32'd0); // sw flag gated off
  endtask

  // --------------------------------------
  // Sequence
  // --------------------------------------
  initial begin
    seed      = 44758;
    begintest = 1'b0;
    reset     = 1'b1;
    issue     = 1'b0;
    instr     = '0;
    rsData    = '0;
    rtData    = '0;
    repeat (3) @(posedge begintest); // Reset for 3 cycles
    @(negedge begintest);
    reset = 1'b0;
    resetState();
    rTypeOps();
    immediateOps();
    branchZero();
    memJumpFlags();
    backToBack();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
+incdir+bench
src/mipsExecPkg.sv
src/mainControl.sv
src/aluControl.sv
src/instrDecode.sv
src/alu.sv
src/resultStage.sv
src/mipsExec.sv
bench/mipsExecTb.sv

/* Makefile */
# Verilator build and run for the execute slice testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mipsExecTb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = TB FAILED
PASS_MSG  = TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
